//--- hdl/gpio_regs.sv
`timescale 1ns/1ps
`include "periph_cfg.svh"

module gpio_regs
	import periph_pkg::*;
(
	input logic wb_clk_i,
	input logic wb_rst_i,
	input periph_req_t req_i,
	output periph_rsp_t rsp_o,
	input logic [`GPIO_W-1:0] gpio_i,
	output logic [`GPIO_W-1:0] gpio_o,
	output logic [`GPIO_W-1:0] gpio_oe_o
);

	localparam int PAD_W = `PERIPH_DATA_W - `GPIO_W;

	logic [`GPIO_W-1:0] out_q;
	logic [`GPIO_W-1:0] oe_q;
	logic [`GPIO_W-1:0] in_meta_q;
	logic [`GPIO_W-1:0] in_sync_q;
	logic [1:0] reg_idx;
	logic [`PERIPH_DATA_W-1:0] out_ext;
	logic [`PERIPH_DATA_W-1:0] oe_ext;
	logic [`PERIPH_DATA_W-1:0] in_ext;
	logic [`PERIPH_DATA_W-1:0] out_next;
	logic [`PERIPH_DATA_W-1:0] oe_next;

	assign reg_idx = req_i.address[3:2];

	assign out_ext = {{PAD_W{1'b0}}, out_q};
	assign oe_ext = {{PAD_W{1'b0}}, oe_q};
	assign in_ext = {{PAD_W{1'b0}}, in_sync_q};

	assign out_next = apply_byte_sel(out_ext, req_i.data_write, req_i.byte_select);
	assign oe_next = apply_byte_sel(oe_ext, req_i.data_write, req_i.byte_select);

	// no wait states, so a write strobe always commits.
	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			out_q <= '0;
			oe_q <= '0;
		end else if (req_i.we) begin
			if (reg_idx == `GPIO_REG_OUT) begin
				out_q <= out_next[`GPIO_W-1:0];
			end
			if (reg_idx == `GPIO_REG_OE) begin
				oe_q <= oe_next[`GPIO_W-1:0];
			end
		end
	end

	// two-flop synchronizer on the pins.
	always_ff @(posedge wb_clk_i) begin
		in_meta_q <= gpio_i;
		in_sync_q <= in_meta_q;
	end

	always_comb begin
		rsp_o.busy = 1'b0;
		rsp_o.error = 1'b0;
		case (reg_idx)
			`GPIO_REG_OUT: rsp_o.data_read = out_ext;
			`GPIO_REG_OE: rsp_o.data_read = oe_ext;
			`GPIO_REG_IN: rsp_o.data_read = in_ext;
			default: rsp_o.data_read = '0;
		endcase
	end

	assign gpio_o = out_q;
	assign gpio_oe_o = oe_q;

endmodule

//--- hdl/periph_addr_decode.sv
`timescale 1ns/1ps
`include "periph_cfg.svh"

module periph_addr_decode
	import periph_pkg::*;
(
	input periph_req_t req_i,
	output periph_rsp_t rsp_o,
	output periph_req_t gpio_req_o,
	output periph_req_t timer_req_o,
	input periph_rsp_t gpio_rsp_i,
	input periph_rsp_t timer_rsp_i
);

	periph_dev_e dev;
	logic [7:0] region;

	// region lives in the top byte of the address.
	assign region = req_i.address[`PERIPH_ADDR_W-1 -: 8];

	always_comb begin
		case (region)
			`REGION_GPIO: dev = DEV_GPIO;
			`REGION_TIMER: dev = DEV_TIMER;
			default: dev = DEV_NONE;
		endcase
	end

	// every device sees the bus, only the selected one sees strobes.
	always_comb begin
		gpio_req_o = req_i;
		timer_req_o = req_i;
		if (dev != DEV_GPIO) begin
			gpio_req_o.we = 1'b0;
			gpio_req_o.oe = 1'b0;
		end
		if (dev != DEV_TIMER) begin
			timer_req_o.we = 1'b0;
			timer_req_o.oe = 1'b0;
		end
	end

	always_comb begin
		case (dev)
			DEV_GPIO: rsp_o = gpio_rsp_i;
			DEV_TIMER: rsp_o = timer_rsp_i;
			default: rsp_o = RSP_UNMAPPED;
		endcase
	end

endmodule

//--- hdl/periph_cfg.svh
`ifndef PERIPH_CFG_SVH
`define PERIPH_CFG_SVH

// peripheral bus widths.
`define PERIPH_ADDR_W 24
`define PERIPH_DATA_W 32
`define PERIPH_SEL_W 4

// device regions, compared against address bits 23:16.
`define REGION_GPIO 8'h00
`define REGION_TIMER 8'h01

// register index within a device, taken from address bits 3:2.
`define GPIO_REG_OUT 2'd0
`define GPIO_REG_OE 2'd1
`define GPIO_REG_IN 2'd2

`define TMR_REG_CTRL 2'd0
`define TMR_REG_COUNT 2'd1
`define TMR_REG_CMP 2'd2
`define TMR_REG_STATUS 2'd3

`define GPIO_W 16

`endif

//--- hdl/periph_pkg.sv
`include "periph_cfg.svh"

package periph_pkg;

	typedef struct packed {
		logic we;
		logic oe;
		logic [`PERIPH_ADDR_W-1:0] address;
		logic [`PERIPH_SEL_W-1:0] byte_select;
		logic [`PERIPH_DATA_W-1:0] data_write;
	} periph_req_t;

	typedef struct packed {
		logic busy;
		logic error; // no device decoded.
		logic [`PERIPH_DATA_W-1:0] data_read;
	} periph_rsp_t;

	typedef enum logic [1:0] {
		DEV_GPIO,
		DEV_TIMER,
		DEV_NONE
	} periph_dev_e;

	// returned for an address that hits no device.
	localparam periph_rsp_t RSP_UNMAPPED = '{busy: 1'b0, error: 1'b1, data_read: '1};

	// merge new data into a register, one byte lane per select bit.
	function automatic logic [`PERIPH_DATA_W-1:0] apply_byte_sel(
		input logic [`PERIPH_DATA_W-1:0] old_val,
		input logic [`PERIPH_DATA_W-1:0] new_val,
		input logic [`PERIPH_SEL_W-1:0] sel
	);
		logic [`PERIPH_DATA_W-1:0] res;
		res = old_val;
		for (int i = 0; i < `PERIPH_SEL_W; i++) begin
			if (sel[i]) begin
				res[8*i +: 8] = new_val[8*i +: 8];
			end
		end
		return res;
	endfunction

endpackage

//--- hdl/periph_subsys_top.sv
`timescale 1ns/1ps
`include "periph_cfg.svh"

module periph_subsys_top
	import periph_pkg::*;
(
	input logic wb_clk_i,
	input logic wb_rst_i,
	input logic wb_stb_i,
	input logic wb_cyc_i,
	input logic wb_we_i,
	input logic [`PERIPH_SEL_W-1:0] wb_sel_i,
	input logic [`PERIPH_DATA_W-1:0] wb_data_i,
	input logic [`PERIPH_ADDR_W-1:0] wb_adr_i,
	output logic wb_ack_o,
	output logic wb_stall_o,
	output logic wb_error_o,
	output logic [`PERIPH_DATA_W-1:0] wb_data_o,
	input logic [`GPIO_W-1:0] gpio_i,
	output logic [`GPIO_W-1:0] gpio_o,
	output logic [`GPIO_W-1:0] gpio_oe_o,
	output logic timer_match_o
);

	periph_req_t bus_req;
	periph_rsp_t bus_rsp;
	periph_req_t gpio_req;
	periph_rsp_t gpio_rsp;
	periph_req_t timer_req;
	periph_rsp_t timer_rsp;

	wb_periph_bus_if u_bridge (
		.wb_clk_i(wb_clk_i),
		.wb_rst_i(wb_rst_i),
		.wb_stb_i(wb_stb_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_we_i(wb_we_i),
		.wb_sel_i(wb_sel_i),
		.wb_data_i(wb_data_i),
		.wb_adr_i(wb_adr_i),
		.wb_ack_o(wb_ack_o),
		.wb_stall_o(wb_stall_o),
		.wb_error_o(wb_error_o),
		.wb_data_o(wb_data_o),
		.periph_req_o(bus_req),
		.periph_rsp_i(bus_rsp)
	);

	periph_addr_decode u_decode (
		.req_i(bus_req),
		.rsp_o(bus_rsp),
		.gpio_req_o(gpio_req),
		.timer_req_o(timer_req),
		.gpio_rsp_i(gpio_rsp),
		.timer_rsp_i(timer_rsp)
	);

	gpio_regs u_gpio (
		.wb_clk_i(wb_clk_i),
		.wb_rst_i(wb_rst_i),
		.req_i(gpio_req),
		.rsp_o(gpio_rsp),
		.gpio_i(gpio_i),
		.gpio_o(gpio_o),
		.gpio_oe_o(gpio_oe_o)
	);

	timer_regs u_timer (
		.wb_clk_i(wb_clk_i),
		.wb_rst_i(wb_rst_i),
		.req_i(timer_req),
		.rsp_o(timer_rsp),
		.match_o(timer_match_o)
	);

endmodule

//--- hdl/timer_regs.sv
`timescale 1ns/1ps
`include "periph_cfg.svh"

module timer_regs
	import periph_pkg::*;
(
	input logic wb_clk_i,
	input logic wb_rst_i,
	input periph_req_t req_i,
	output periph_rsp_t rsp_o,
	output logic match_o
);

	logic enable_q;
	logic [`PERIPH_DATA_W-1:0] count_q;
	logic [`PERIPH_DATA_W-1:0] cmp_q;
	logic status_q;
	logic pending_q;
	logic access;
	logic busy;
	logic wr;
	logic [1:0] reg_idx;
	logic [`PERIPH_DATA_W-1:0] count_next;
	logic [`PERIPH_DATA_W-1:0] cmp_next;

	assign reg_idx = req_i.address[3:2];
	assign access = req_i.we | req_i.oe;

	// first cycle of an access is always a wait state.
	assign busy = access & ~pending_q;
	assign wr = req_i.we & ~busy;

	assign count_next = apply_byte_sel(count_q, req_i.data_write, req_i.byte_select);
	assign cmp_next = apply_byte_sel(cmp_q, req_i.data_write, req_i.byte_select);

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			pending_q <= 1'b0;
		end else begin
			pending_q <= busy; // drops on the completing edge.
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			enable_q <= 1'b0;
			count_q <= '0;
			cmp_q <= '0;
			status_q <= 1'b0;
		end else begin
			if (wr && reg_idx == `TMR_REG_CTRL && req_i.byte_select[0]) begin
				enable_q <= req_i.data_write[0];
			end

			if (wr && reg_idx == `TMR_REG_COUNT) begin
				count_q <= count_next;
			end else if (enable_q) begin
				count_q <= count_q + 1'b1;
			end

			if (wr && reg_idx == `TMR_REG_CMP) begin
				cmp_q <= cmp_next;
			end

			// write one to clear wins over a new match.
			if (wr && reg_idx == `TMR_REG_STATUS && req_i.byte_select[0]
					&& req_i.data_write[0]) begin
				status_q <= 1'b0;
			end else if (enable_q && count_q == cmp_q) begin
				status_q <= 1'b1;
			end
		end
	end

	always_comb begin
		rsp_o.busy = busy;
		rsp_o.error = 1'b0;
		case (reg_idx)
			`TMR_REG_CTRL: rsp_o.data_read = {{(`PERIPH_DATA_W-1){1'b0}}, enable_q};
			`TMR_REG_COUNT: rsp_o.data_read = count_q;
			`TMR_REG_CMP: rsp_o.data_read = cmp_q;
			default: rsp_o.data_read = {{(`PERIPH_DATA_W-1){1'b0}}, status_q};
		endcase
	end

	assign match_o = status_q;

endmodule

//--- hdl/wb_periph_bus_if.sv
`timescale 1ns/1ps
`include "periph_cfg.svh"

module wb_periph_bus_if
	import periph_pkg::*;
(
	input logic wb_clk_i,
	input logic wb_rst_i,
	input logic wb_stb_i,
	input logic wb_cyc_i,
	input logic wb_we_i,
	input logic [`PERIPH_SEL_W-1:0] wb_sel_i,
	input logic [`PERIPH_DATA_W-1:0] wb_data_i,
	input logic [`PERIPH_ADDR_W-1:0] wb_adr_i,
	output logic wb_ack_o,
	output logic wb_stall_o,
	output logic wb_error_o,
	output logic [`PERIPH_DATA_W-1:0] wb_data_o,
	output periph_req_t periph_req_o,
	input periph_rsp_t periph_rsp_i
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WRITE,
		ST_READ,
		ST_FINISH
	} state_e;

	state_e state_q;
	logic [`PERIPH_ADDR_W-1:0] addr_q;
	logic [`PERIPH_SEL_W-1:0] sel_q;
	logic stall_q;
	logic ack_q;
	logic error_q;
	logic [`PERIPH_DATA_W-1:0] rdata_q;

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			state_q <= ST_IDLE;
			stall_q <= 1'b0;
			ack_q <= 1'b0;
			error_q <= 1'b0;
			rdata_q <= '1;
		end else begin
			case (state_q)
				ST_IDLE: begin
					ack_q <= 1'b0;
					error_q <= 1'b0;
					rdata_q <= '1;
					if (wb_cyc_i && wb_stb_i) begin
						addr_q <= wb_adr_i;
						sel_q <= wb_sel_i;
						stall_q <= 1'b1; // held until the access is done.
						state_q <= wb_we_i ? ST_WRITE : ST_READ;
					end else begin
						stall_q <= 1'b0;
					end
				end

				ST_WRITE, ST_READ: begin
					if (!periph_rsp_i.busy) begin
						state_q <= ST_FINISH;
						if (periph_rsp_i.error) begin
							error_q <= 1'b1;
						end else begin
							ack_q <= 1'b1;
						end
						if (state_q == ST_READ) begin
							rdata_q <= periph_rsp_i.data_read; // unmapped reads give all ones.
						end
					end
				end

				ST_FINISH: begin
					state_q <= ST_IDLE;
					stall_q <= 1'b0;
					ack_q <= 1'b0;
					error_q <= 1'b0;
					rdata_q <= '1;
				end

				default: begin
					state_q <= ST_IDLE;
					stall_q <= 1'b0;
				end
			endcase
		end
	end

	// request comes straight from state; write data passes through from the master.
	always_comb begin
		periph_req_o = '0;
		if (state_q != ST_IDLE) begin
			periph_req_o.address = addr_q;
			periph_req_o.byte_select = sel_q;
		end
		periph_req_o.we = (state_q == ST_WRITE);
		periph_req_o.oe = (state_q == ST_READ);
		if (state_q == ST_WRITE) begin
			periph_req_o.data_write = wb_data_i;
		end
	end

	assign wb_ack_o = ack_q;
	assign wb_error_o = error_q;
	assign wb_stall_o = stall_q;
	assign wb_data_o = rdata_q;

endmodule

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f verilog.f \
	--top-module tb_periph_subsys --Mdir obj_dir -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^TEST OK$" sim.log; then
	exit 0
fi
echo "pass line not found in sim.log"
exit 1

//--- test/tb_periph_subsys.sv
`timescale 1ns/1ps
`include "periph_cfg.svh"

module tb_periph_subsys;

	localparam int TIMEOUT_CYCLES = 2000;
	localparam int RESP_LIMIT = 20;
	localparam int MATCH_LIMIT = 50;
	localparam logic [31:0] ALL_ONES = 32'hffff_ffff;
	localparam logic [7:0] REGION_BAD = 8'h05; // no device here.

	logic wb_clk_i;
	logic wb_rst_i;
	logic wb_stb_i;
	logic wb_cyc_i;
	logic wb_we_i;
	logic [`PERIPH_SEL_W-1:0] wb_sel_i;
	logic [`PERIPH_DATA_W-1:0] wb_data_i;
	logic [`PERIPH_ADDR_W-1:0] wb_adr_i;
	logic wb_ack_o;
	logic wb_stall_o;
	logic wb_error_o;
	logic [`PERIPH_DATA_W-1:0] wb_data_o;
	logic [`GPIO_W-1:0] gpio_i;
	logic [`GPIO_W-1:0] gpio_o;
	logic [`GPIO_W-1:0] gpio_oe_o;
	logic timer_match_o;

	int cycle_count = 0;
	logic [31:0] rng_state = 32'd55822;
	logic [31:0] gpio_out_model; // expected OUT and OE contents.
	logic [31:0] gpio_oe_model;

	periph_subsys_top uut (.*);

	initial begin
		wb_clk_i = 1'b0;
		forever #5 wb_clk_i = ~wb_clk_i;
	end

	always @(posedge wb_clk_i) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("simulation timed out after %0d cycles", cycle_count);
			abort_run();
		end
	end

	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
			abort_run();
		end
	endtask

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic logic [`PERIPH_ADDR_W-1:0] reg_addr(input logic [7:0] region,
			input logic [1:0] idx);
		return {region, 12'h0, idx, 2'b00};
	endfunction

	// one single Wishbone cycle; cycles counts edges from acceptance to ack or error.
	task automatic wb_access(input logic we, input logic [`PERIPH_ADDR_W-1:0] adr,
			input logic [`PERIPH_SEL_W-1:0] sel, input logic [`PERIPH_DATA_W-1:0] wdata,
			output logic [`PERIPH_DATA_W-1:0] rdata, output logic ack, output logic err,
			output int cycles);
		int waited;
		waited = 1;
		cycles = 0;
		@(negedge wb_clk_i);
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i = we;
		wb_adr_i = adr;
		wb_sel_i = sel;
		wb_data_i = wdata;
		@(negedge wb_clk_i);
		while (!wb_stall_o) begin
			if (waited >= RESP_LIMIT) begin
				$display("bridge did not accept the request within %0d cycles", RESP_LIMIT);
				abort_run();
			end else begin
				@(negedge wb_clk_i);
				waited++;
			end
		end
		while (!wb_ack_o && !wb_error_o) begin
			check_value("wb_stall_o", wb_stall_o, 1);
			check_value("wb_data_o", wb_data_o, ALL_ONES);
			if (waited >= RESP_LIMIT) begin
				$display("no ack or error within %0d cycles of the request", RESP_LIMIT);
				abort_run();
			end else begin
				@(negedge wb_clk_i);
				waited++;
				cycles++;
			end
		end
		check_value("wb_stall_o", wb_stall_o, 1); // still high in the ack cycle.
		check_value("ack_and_error", wb_ack_o & wb_error_o, 0);
		rdata = wb_data_o;
		ack = wb_ack_o;
		err = wb_error_o;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_data_i = '0;
	endtask

	task automatic wb_write(input logic [`PERIPH_ADDR_W-1:0] adr,
			input logic [`PERIPH_SEL_W-1:0] sel, input logic [`PERIPH_DATA_W-1:0] data,
			output logic ack, output logic err, output int cycles);
		logic [`PERIPH_DATA_W-1:0] unused;
		wb_access(1'b1, adr, sel, data, unused, ack, err, cycles);
	endtask

	task automatic wb_read(input logic [`PERIPH_ADDR_W-1:0] adr,
			output logic [`PERIPH_DATA_W-1:0] data, output logic ack, output logic err,
			output int cycles);
		wb_access(1'b0, adr, 4'hf, '0, data, ack, err, cycles);
	endtask

	task automatic write_reg(input logic [`PERIPH_ADDR_W-1:0] adr,
			input logic [`PERIPH_SEL_W-1:0] sel, input logic [31:0] data, input int exp_cycles);
		logic ack;
		logic err;
		int cycles;
		wb_write(adr, sel, data, ack, err, cycles);
		check_value("wb_ack_o", ack, 1);
		check_value("wb_error_o", err, 0);
		check_value("ack_latency", cycles, exp_cycles);
	endtask

	task automatic read_reg(input logic [`PERIPH_ADDR_W-1:0] adr, input int exp_cycles,
			output logic [31:0] data);
		logic ack;
		logic err;
		int cycles;
		wb_read(adr, data, ack, err, cycles);
		check_value("wb_ack_o", ack, 1);
		check_value("wb_error_o", err, 0);
		check_value("ack_latency", cycles, exp_cycles);
	endtask

	task automatic test_reset_state();
		check_value("wb_ack_o", wb_ack_o, 0);
		check_value("wb_error_o", wb_error_o, 0);
		check_value("wb_stall_o", wb_stall_o, 0);
		check_value("wb_data_o", wb_data_o, ALL_ONES);
		check_value("gpio_o", gpio_o, 0);
		check_value("gpio_oe_o", gpio_oe_o, 0);
		check_value("timer_match_o", timer_match_o, 0);
	endtask

	task automatic test_gpio();
		logic [31:0] val;
		logic [31:0] rd;
		val = lcg_next();
		gpio_out_model = {16'h0, val[15:0]};
		write_reg(reg_addr(`REGION_GPIO, `GPIO_REG_OUT), 4'hf, val, 1);
		read_reg(reg_addr(`REGION_GPIO, `GPIO_REG_OUT), 1, rd);
		check_value("gpio_out_reg", rd, gpio_out_model);
		check_value("gpio_o", gpio_o, gpio_out_model);
		// only the low byte lane is selected.
		val = lcg_next();
		gpio_out_model[7:0] = val[7:0];
		write_reg(reg_addr(`REGION_GPIO, `GPIO_REG_OUT), 4'b0001, val, 1);
		read_reg(reg_addr(`REGION_GPIO, `GPIO_REG_OUT), 1, rd);
		check_value("gpio_out_reg", rd, gpio_out_model);
		check_value("gpio_o", gpio_o, gpio_out_model);
		val = lcg_next();
		gpio_oe_model = {16'h0, val[15:0]};
		write_reg(reg_addr(`REGION_GPIO, `GPIO_REG_OE), 4'hf, val, 1);
		read_reg(reg_addr(`REGION_GPIO, `GPIO_REG_OE), 1, rd);
		check_value("gpio_oe_reg", rd, gpio_oe_model);
		check_value("gpio_oe_o", gpio_oe_o, gpio_oe_model);
		val = lcg_next();
		gpio_i = val[15:0];
		repeat (3) @(negedge wb_clk_i);
		read_reg(reg_addr(`REGION_GPIO, `GPIO_REG_IN), 1, rd);
		check_value("gpio_in_reg", rd, {16'h0, val[15:0]});
	endtask

	task automatic test_timer_regs();
		logic [31:0] val;
		logic [31:0] rd;
		read_reg(reg_addr(`REGION_TIMER, `TMR_REG_CTRL), 2, rd);
		check_value("timer_ctrl", rd, 0);
		val = lcg_next();
		write_reg(reg_addr(`REGION_TIMER, `TMR_REG_COUNT), 4'hf, val, 2);
		read_reg(reg_addr(`REGION_TIMER, `TMR_REG_COUNT), 2, rd);
		check_value("timer_count", rd, val);
		val = lcg_next() | 32'h8000_0000; // kept far above the counts used later.
		write_reg(reg_addr(`REGION_TIMER, `TMR_REG_CMP), 4'hf, val, 2);
		read_reg(reg_addr(`REGION_TIMER, `TMR_REG_CMP), 2, rd);
		check_value("timer_cmp", rd, val);
	endtask

	task automatic test_timer_run();
		logic [31:0] c1;
		logic [31:0] c2;
		logic [31:0] rd;
		int waited;
		write_reg(reg_addr(`REGION_TIMER, `TMR_REG_COUNT), 4'hf, lcg_next() & 32'hffff, 2);
		write_reg(reg_addr(`REGION_TIMER, `TMR_REG_CTRL), 4'hf, 32'h1, 2);
		read_reg(reg_addr(`REGION_TIMER, `TMR_REG_COUNT), 2, c1);
		read_reg(reg_addr(`REGION_TIMER, `TMR_REG_COUNT), 2, c2);
		check_value("count_increasing", c2 > c1, 1);
		write_reg(reg_addr(`REGION_TIMER, `TMR_REG_CMP), 4'hf, c2 + 32'd24, 2);
		check_value("timer_match_o", timer_match_o, 0);
		waited = 0;
		while (!timer_match_o) begin
			if (waited >= MATCH_LIMIT) begin
				$display("timer match not seen within %0d cycles", MATCH_LIMIT);
				abort_run();
			end else begin
				@(negedge wb_clk_i);
				waited++;
			end
		end
		read_reg(reg_addr(`REGION_TIMER, `TMR_REG_STATUS), 2, rd);
		check_value("timer_status", rd, 1);
		write_reg(reg_addr(`REGION_TIMER, `TMR_REG_STATUS), 4'hf, 32'h1, 2);
		read_reg(reg_addr(`REGION_TIMER, `TMR_REG_STATUS), 2, rd);
		check_value("timer_status", rd, 0);
		check_value("timer_match_o", timer_match_o, 0);
	endtask

	task automatic test_unmapped();
		logic [31:0] rd;
		logic ack;
		logic err;
		int cycles;
		wb_read(reg_addr(REGION_BAD, 2'd0), rd, ack, err, cycles);
		check_value("wb_error_o", err, 1);
		check_value("wb_ack_o", ack, 0);
		check_value("wb_data_o", rd, ALL_ONES);
		check_value("error_latency", cycles, 1);
		// index 0 matches GPIO OUT and timer CTRL, so a leak would show there.
		wb_write(reg_addr(REGION_BAD, 2'd0), 4'hf, lcg_next() & 32'hffff_fffe, ack, err, cycles);
		check_value("wb_error_o", err, 1);
		check_value("wb_ack_o", ack, 0);
		read_reg(reg_addr(`REGION_GPIO, `GPIO_REG_OUT), 1, rd);
		check_value("gpio_out_reg", rd, gpio_out_model);
		read_reg(reg_addr(`REGION_TIMER, `TMR_REG_CTRL), 2, rd);
		check_value("timer_ctrl", rd, 1);
	endtask

	task automatic test_back_to_back();
		logic [31:0] val;
		logic [31:0] rd;
		val = lcg_next();
		gpio_out_model = {16'h0, val[15:0]};
		write_reg(reg_addr(`REGION_GPIO, `GPIO_REG_OUT), 4'hf, val, 1);
		read_reg(reg_addr(`REGION_GPIO, `GPIO_REG_OUT), 1, rd);
		check_value("gpio_out_reg", rd, gpio_out_model);
		read_reg(reg_addr(`REGION_TIMER, `TMR_REG_CTRL), 2, rd);
		check_value("timer_ctrl", rd, 1);
		read_reg(reg_addr(`REGION_GPIO, `GPIO_REG_OE), 1, rd);
		check_value("gpio_oe_reg", rd, gpio_oe_model);
		@(negedge wb_clk_i);
		check_value("wb_stall_o", wb_stall_o, 0);
		check_value("wb_ack_o", wb_ack_o, 0);
		check_value("wb_data_o", wb_data_o, ALL_ONES);
	endtask

	initial begin
		wb_rst_i = 1'b1;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_sel_i = '0;
		wb_data_i = '0;
		wb_adr_i = '0;
		gpio_i = '0;
		gpio_out_model = '0;
		gpio_oe_model = '0;
		repeat (3) @(negedge wb_clk_i);
		wb_rst_i = 1'b0;
		test_reset_state();
		test_gpio();
		test_timer_regs();
		test_timer_run();
		test_unmapped();
		test_back_to_back();
		$display("TEST OK");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+hdl
hdl/periph_pkg.sv
hdl/wb_periph_bus_if.sv
hdl/periph_addr_decode.sv
hdl/gpio_regs.sv
hdl/timer_regs.sv
hdl/periph_subsys_top.sv
test/tb_periph_subsys.sv
